/* rtl/sensor_hub_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and constants of the sensor hub
// Channel ids are 3 bits, so num_channels must stay at 8 or less
// A frame is sync, id, four data bytes MSB first, then the XOR checksum
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package sensor_hub_pkg;

	localparam int num_channels = 8;

	typedef logic [2:0] channel_id_t;

	// One transfer from the arbiter to the framer
	typedef struct packed
	{
		channel_id_t channel;
		logic [31:0] data;
	} sensor_sample_s;

	// Fixed sample word of each emulated sensor
	localparam logic [31:0] sensor_pattern [num_channels] = '{
		32'h41624364, // "AbCd"
		32'h00005B5D,
		32'h00006E49,
		32'h00003B29,
		32'h00002829,
		32'h00003725,
		32'h0000780A,
		32'h00007B6C
	};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Frame layout
	localparam logic [7:0] frame_sync = 8'hA5;
	localparam int frame_length = 7; // Bytes per frame, checksum included

endpackage

/* rtl/sensor_analog.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Emulated sensors with one shared interval timer
// sample_interval must be 2 or more; all channels tick together
// Pending flags are cleared by take; overrun bits clear only on reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sensor_analog
#(
	parameter logic [15:0] sample_interval = 16'd200
)
(
	input  logic                                          clock,
	input  logic                                          reset,
	input  logic [sensor_hub_pkg::num_channels-1:0]       channel_enable,
	input  logic [sensor_hub_pkg::num_channels-1:0]       take,
	output logic [sensor_hub_pkg::num_channels-1:0]       pending,
	output logic [sensor_hub_pkg::num_channels-1:0][31:0] data_words,
	output logic [sensor_hub_pkg::num_channels-1:0]       overrun
);
	import sensor_hub_pkg::*;

	typedef enum logic [1:0]
	{
		timer_restart,
		timer_counting,
		timer_tick
	} timer_state_t;

	timer_state_t timer_state;
	timer_state_t timer_next;
	logic [15:0]  timer;
	logic         tick;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Interval timer and tick FSM
	always_comb
	begin
		case (timer_state)
			timer_restart:  timer_next = timer_counting;
			timer_counting:
			begin
				if (timer == sample_interval - 16'd2)
					timer_next = timer_tick; // Timer reaches interval - 1 next cycle
				else
					timer_next = timer_counting;
			end
			timer_tick:     timer_next = timer_counting;
			default:        timer_next = timer_restart;
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			timer_state <= timer_restart;
			timer <= '0;
		end
		else
		begin
			timer_state <= timer_next;
			if (timer_state == timer_counting)
				timer <= timer + 16'd1;
			else
				timer <= '0; // Restart holds, tick wraps
		end
	end

	assign tick = (timer_state == timer_tick);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Per-channel sample word, pending flag and overrun bit
	for (genvar i = 0; i < num_channels; i++)
	begin : g_channel
		assign data_words[i] = sensor_pattern[i];

		always_ff @(posedge clock or posedge reset)
		begin
			if (reset)
			begin
				pending[i] <= 1'b0;
				overrun[i] <= 1'b0;
			end
			else
			begin
				if (tick && channel_enable[i])
					pending[i] <= 1'b1; // Tick wins over a take in the same cycle
				else if (take[i])
					pending[i] <= 1'b0;

				// Previous sample never taken, so it is lost
				if (tick && channel_enable[i] && pending[i] && !take[i])
					overrun[i] <= 1'b1;
			end
		end
	end

endmodule

/* rtl/stream_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin pick among pending channels
// Search starts one above the last grant, channel 0 after reset
// One sample per four-phase cycle; take pulses once per grant
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module stream_arbiter
(
	input  logic                                          clock,
	input  logic                                          reset,
	input  logic [sensor_hub_pkg::num_channels-1:0]       pending,
	input  logic [sensor_hub_pkg::num_channels-1:0][31:0] data_words,
	output logic [sensor_hub_pkg::num_channels-1:0]       take,
	output sensor_hub_pkg::sensor_sample_s                sample,
	output logic                                          sample_req,
	input  logic                                          sample_ack
);
	import sensor_hub_pkg::*;

	channel_id_t rr_ptr;      // First channel to look at
	channel_id_t search_id;
	channel_id_t grant_id;
	logic        grant_valid;
	logic        pick;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Search from rr_ptr upwards, wrapping at the top
	always_comb
	begin
		grant_valid = 1'b0;
		grant_id = rr_ptr;
		search_id = rr_ptr;
		for (int k = 0; k < num_channels; k++)
		begin
			search_id = rr_ptr + channel_id_t'(k);
			if (!grant_valid && pending[search_id])
			begin
				grant_valid = 1'b1;
				grant_id = search_id;
			end
		end
	end

	// Only start when both handshake lines are back at zero
	assign pick = grant_valid && !sample_req && !sample_ack;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Four-phase sender
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			rr_ptr <= '0;
			sample_req <= 1'b0;
			take <= '0;
		end
		else
		begin
			take <= '0; // Single-cycle pulse
			if (pick)
			begin
				sample_req <= 1'b1;
				take[grant_id] <= 1'b1;
				rr_ptr <= grant_id + 3'd1;
			end
			else if (sample_req && sample_ack)
			begin
				sample_req <= 1'b0; // Framer has latched the sample
			end
		end
	end

	// Sample held stable for the whole request phase
	always_ff @(posedge clock)
	begin
		if (pick)
		begin
			sample.channel <= grant_id;
			sample.data <= data_words[grant_id];
		end
	end

endmodule

/* rtl/packet_framer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sample to byte framer with four-phase ports on both sides
// Each byte needs a full req/ack cycle, so frame time follows the sink
// No new sample is taken until the last byte_ack has fallen
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module packet_framer
(
	input  logic                           clock,
	input  logic                           reset,
	input  sensor_hub_pkg::sensor_sample_s sample,
	input  logic                           sample_req,
	output logic                           sample_ack,
	output logic [7:0]                     byte_data,
	output logic                           byte_req,
	input  logic                           byte_ack
);
	import sensor_hub_pkg::*;

	localparam logic [2:0] end_index = 3'(frame_length);      // Past the last byte
	localparam logic [2:0] checksum_index = 3'(frame_length - 1);

	sensor_sample_s frame_sample;
	logic           frame_busy;
	logic [2:0]     byte_index;   // Byte now held in byte_data
	logic [7:0]     checksum;
	logic [7:0]     next_byte;
	logic           accept;
	logic           byte_taken;
	logic           byte_gap;
	logic           byte_load;
	logic           frame_end;

	assign accept = !frame_busy && sample_req && !sample_ack;
	assign byte_taken = byte_req && byte_ack;
	assign byte_gap = frame_busy && !byte_req && !byte_ack; // Output back to idle
	assign byte_load = byte_gap && (byte_index != end_index);
	assign frame_end = byte_gap && (byte_index == end_index);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Byte selection by position in the frame
	always_comb
	begin
		case (byte_index)
			3'd0:    next_byte = frame_sync;
			3'd1:    next_byte = {5'b00000, frame_sample.channel};
			3'd2:    next_byte = frame_sample.data[31:24];
			3'd3:    next_byte = frame_sample.data[23:16];
			3'd4:    next_byte = frame_sample.data[15:8];
			3'd5:    next_byte = frame_sample.data[7:0];
			3'd6:    next_byte = checksum;
			default: next_byte = 8'h00;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Handshake control
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			sample_ack <= 1'b0;
			frame_busy <= 1'b0;
			byte_req <= 1'b0;
			byte_index <= '0;
		end
		else
		begin
			// Input side
			if (accept)
				sample_ack <= 1'b1;
			else if (sample_ack && !sample_req)
				sample_ack <= 1'b0;

			// Output side
			if (accept)
			begin
				frame_busy <= 1'b1;
				byte_req <= 1'b1; // Sync byte goes out at once
				byte_index <= '0;
			end
			else if (byte_taken)
			begin
				byte_req <= 1'b0;
				byte_index <= byte_index + 3'd1;
			end
			else if (byte_load)
			begin
				byte_req <= 1'b1;
			end
			else if (frame_end)
			begin
				frame_busy <= 1'b0;
			end
		end
	end

	// Payload: latched sample, output byte and running checksum
	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			frame_sample <= sample;
			byte_data <= frame_sync;
			checksum <= 8'h00;
		end
		else if (byte_load)
		begin
			byte_data <= next_byte;
			if (byte_index != checksum_index)
				checksum <= checksum ^ next_byte; // Id and data bytes only
		end
	end

endmodule

/* rtl/sensor_hub_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sensor hub: emulated sensors, round-robin arbiter and byte framer
// byte_req/byte_ack is a four-phase port; hold byte_ack to stall
// A long stall shows up as sticky overrun bits per channel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sensor_hub_top
#(
	parameter logic [15:0] sample_interval = 16'd200 // Clock cycles per tick
)
(
	input  logic                                    clock,
	input  logic                                    reset,
	input  logic [sensor_hub_pkg::num_channels-1:0] channel_enable,
	output logic [7:0]                              byte_data,
	output logic                                    byte_req,
	input  logic                                    byte_ack,
	output logic [sensor_hub_pkg::num_channels-1:0] overrun
);
	import sensor_hub_pkg::*;

	logic [num_channels-1:0]       pending;
	logic [num_channels-1:0]       take;
	logic [num_channels-1:0][31:0] data_words;
	sensor_sample_s                sample;
	logic                          sample_req;
	logic                          sample_ack;

	sensor_analog #(
		.sample_interval(sample_interval)
	) u_analog (
		.clock         (clock),
		.reset         (reset),
		.channel_enable(channel_enable),
		.take          (take),
		.pending       (pending),
		.data_words    (data_words),
		.overrun       (overrun)
	);

	stream_arbiter u_arbiter (
		.clock     (clock),
		.reset     (reset),
		.pending   (pending),
		.data_words(data_words),
		.take      (take),
		.sample    (sample),
		.sample_req(sample_req),
		.sample_ack(sample_ack)
	);

	packet_framer u_framer (
		.clock     (clock),
		.reset     (reset),
		.sample    (sample),
		.sample_req(sample_req),
		.sample_ack(sample_ack),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.byte_ack  (byte_ack)
	);

endmodule

/* bench/clock_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bench clock and power-on reset
// Reset is held high for the first two clock cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module clock_gen
#(
	parameter int period = 20 // ns
)
(
	output logic clock,
	output logic reset
);

	initial
	begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	initial
	begin
		reset = 1'b1;
		repeat (2) @(negedge clock);
		reset = 1'b0; // Released on a falling edge
	end

endmodule

/* bench/sensor_hub_chk.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Handshake rules of the sensor hub, bound into sensor_hub_top
// Checks are off while reset is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sensor_hub_chk
(
	input logic       clock,
	input logic       reset,
	input logic [7:0] byte_data,
	input logic       byte_req,
	input logic       byte_ack,
	input logic       sample_req,
	input logic       sample_ack
);

	// Output byte held for the whole request phase
	byte_data_stable: assert property (@(posedge clock) disable iff (reset)
		byte_req && $past(byte_req) |-> $stable(byte_data))
		else $error("byte_data changed while byte_req was high");

	// No new request before the previous acknowledge is gone
	sample_req_rise: assert property (@(posedge clock) disable iff (reset)
		$rose(sample_req) |-> !$past(sample_ack))
		else $error("sample_req rose while sample_ack was high");

	byte_req_rise: assert property (@(posedge clock) disable iff (reset)
		$rose(byte_req) |-> !$past(byte_ack))
		else $error("byte_req rose while byte_ack was high");

endmodule

bind sensor_hub_top sensor_hub_chk chk0 (
	.clock     (clock),
	.reset     (reset),
	.byte_data (byte_data),
	.byte_req  (byte_req),
	.byte_ack  (byte_ack),
	.sample_req(sample_req),
	.sample_ack(sample_ack)
);

/* bench/sensor_hub_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed tests of the sensor hub over its byte req/ack port
// Assumes the default sample_interval of the top level (200 cycles)
// Inputs change on the falling edge, outputs are sampled there too
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sensor_hub_tb;
	import sensor_hub_pkg::*;

	localparam int sample_interval = 200;
	localparam int wait_limit = 4 * sample_interval; // Cycles per wait

	logic                    clock;
	logic                    power_on_reset;
	logic                    bench_reset;
	logic                    reset;
	logic [num_channels-1:0] channel_enable;
	logic [7:0]              byte_data;
	logic                    byte_req;
	logic                    byte_ack;
	logic [num_channels-1:0] overrun;

	logic [7:0] rx_bytes [frame_length]; // Last frame received
	int         frame_start_cycle;       // Cycle of its first byte
	int         cycle_count = 0;
	int         check_errors = 0;
	int         timeout_errors = 0;
	integer     seed = 50250;

	clock_gen clock0 (
		.clock(clock),
		.reset(power_on_reset)
	);

	assign reset = power_on_reset || bench_reset;

	sensor_hub_top dut0 (
		.clock         (clock),
		.reset         (reset),
		.channel_enable(channel_enable),
		.byte_data     (byte_data),
		.byte_req      (byte_req),
		.byte_ack      (byte_ack),
		.overrun       (overrun)
	);

	always @(posedge clock)
		cycle_count <= cycle_count + 1;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Expected frame is sync, id, data MSB first, then XOR of id and data
	function automatic logic [55:0] expected_frame(input int channel);
		logic [31:0] word;
		logic [7:0]  id;
		logic [7:0]  sum;
		word = sensor_pattern[channel];
		id = 8'(channel);
		sum = id ^ word[31:24] ^ word[23:16] ^ word[15:8] ^ word[7:0];
		return {frame_sync, id, word, sum};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected)
		else
		begin
			check_errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic check_frame(input int channel);
		logic [55:0] expected;
		logic [7:0]  expected_byte;
		expected = expected_frame(channel);
		for (int i = 0; i < frame_length; i++)
		begin
			expected_byte = expected[55 - 8 * i -: 8];
			assert (rx_bytes[i] === expected_byte)
			else
			begin
				check_errors++;
				$display("CHECK FAILED byte_data (byte %0d, channel %0d): got %h, expected %h",
					i, channel, rx_bytes[i], expected_byte);
			end
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus helpers
	task automatic apply_reset(input logic [num_channels-1:0] enable);
		@(negedge clock);
		channel_enable = enable;
		byte_ack = 1'b0;
		bench_reset = 1'b1;
		repeat (2) @(negedge clock);
		bench_reset = 1'b0;
	endtask

	task automatic wait_byte_req(input logic level, output logic seen);
		int count;
		count = 0;
		seen = 1'b0;
		while (!seen && count < wait_limit)
		begin
			@(negedge clock);
			seen = (byte_req === level);
			count++;
		end
		if (!seen)
		begin
			timeout_errors++;
			$display("Timeout: byte_req did not go to %0d within %0d cycles", level, wait_limit);
		end
	endtask

	// Four-phase receiver; the first byte may be held for first_stall cycles
	task automatic receive_bytes(input int count, input int max_delay,
		input int first_stall, output logic ok);
		int   delay;
		logic seen;
		ok = 1'b1;
		for (int i = 0; i < count; i++)
		begin
			wait_byte_req(1'b1, seen);
			if (!seen)
			begin
				ok = 1'b0;
				return;
			end
			rx_bytes[i] = byte_data;
			if (i == 0)
				frame_start_cycle = cycle_count;
			if (i == 0 && first_stall > 0)
				delay = first_stall;
			else if (max_delay > 0)
				delay = $unsigned($random(seed)) % (max_delay + 1);
			else
				delay = 0;
			repeat (delay) @(negedge clock);
			byte_ack = 1'b1;
			wait_byte_req(1'b0, seen);
			byte_ack = 1'b0;
			if (!seen)
			begin
				ok = 1'b0;
				return;
			end
		end
	endtask

	task automatic receive_frame(input int max_delay, input int first_stall, output logic ok);
		receive_bytes(frame_length, max_delay, first_stall, ok);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Directed tests
	task automatic single_channel_frame();
		logic ok;
		$display("Test 1: channel 0 only");
		apply_reset(8'h01);
		receive_frame(0, 0, ok);
		if (ok)
			check_frame(0);
	endtask

	task automatic all_channel_round();
		logic ok;
		$display("Test 2: all channels, random acknowledge delay");
		apply_reset(8'hFF);
		for (int ch = 0; ch < num_channels; ch++)
		begin
			receive_frame(3, 0, ok);
			if (ok)
				check_frame(ch);
		end
		check_value("overrun", overrun, 8'h00);
	endtask

	task automatic masked_channels();
		int   order [4] = '{1, 3, 4, 6};
		int   first_cycle;
		logic ok;
		$display("Test 3: enable mask 5A");
		apply_reset(8'h5A);
		first_cycle = 0;
		for (int k = 0; k < 4; k++)
		begin
			receive_frame(0, 0, ok);
			if (k == 0)
				first_cycle = frame_start_cycle;
			if (ok)
				check_frame(order[k]);
		end
		assert (cycle_count - first_cycle < sample_interval)
		else
		begin
			check_errors++;
			$display("Masked frames took %0d cycles, longer than one interval",
				cycle_count - first_cycle);
		end
		// No other channel may send before the next tick
		while (cycle_count - first_cycle < sample_interval - 2)
		begin
			@(negedge clock);
			check_value("byte_req", byte_req, 1'b0);
			if (byte_req)
				break;
		end
	endtask

	task automatic held_ack_overrun();
		logic ok;
		$display("Test 4: byte_ack withheld");
		apply_reset(8'hFF);
		receive_frame(0, 3 * sample_interval, ok);
		if (ok)
			check_frame(0);
		check_value("overrun & fe", overrun & 8'hFE, 8'hFE);
		// Channel 1 was granted during the stall, then 2 to 7 and 0 follow
		for (int k = 0; k < num_channels; k++)
		begin
			receive_frame(0, 0, ok);
			if (ok)
				check_frame((k + 1) % num_channels);
		end
		check_value("overrun & fe", overrun & 8'hFE, 8'hFE); // Sticky after draining
	endtask

	task automatic disabled_channels_idle();
		$display("Test 5: no channel enabled");
		apply_reset(8'h00);
		for (int c = 0; c < 3 * sample_interval; c++)
		begin
			@(negedge clock);
			check_value("byte_req", byte_req, 1'b0);
			if (byte_req)
				break; // One report is enough
		end
		check_value("overrun", overrun, 8'h00);
	endtask

	task automatic reset_during_frame();
		logic ok;
		logic seen;
		$display("Test 6: reset in the middle of a frame");
		apply_reset(8'hFF);
		receive_bytes(3, 0, 0, ok);
		wait_byte_req(1'b1, seen); // Fourth byte on the port
		apply_reset(8'hFF);
		check_value("byte_req", byte_req, 1'b0);
		check_value("overrun", overrun, 8'h00);
		receive_frame(0, 0, ok);
		if (ok)
			check_frame(0);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial
	begin
		int count;
		channel_enable = '0;
		byte_ack = 1'b0;
		bench_reset = 1'b0;
		count = 0;
		do
		begin
			@(negedge clock);
			count++;
		end
		while (power_on_reset !== 1'b0 && count < 10);
		if (power_on_reset !== 1'b0)
		begin
			timeout_errors++;
			$display("Timeout: power-on reset was not released");
		end

		single_channel_frame();
		all_channel_round();
		masked_channels();
		held_ack_overrun();
		disabled_channels_idle();
		reset_during_frame();

		$display("Errors: %0d check failures, %0d timeouts", check_errors, timeout_errors);
		if (check_errors == 0 && timeout_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* verilog.f */
rtl/sensor_hub_pkg.sv
rtl/sensor_analog.sv
rtl/stream_arbiter.sv
rtl/packet_framer.sv
rtl/sensor_hub_top.sv
bench/clock_gen.sv
bench/sensor_hub_chk.sv
bench/sensor_hub_tb.sv
